/* Makefile */
# Verilator lint and simulation of the execute stage

LOG := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f execute_unit.f --top-module execute_unit

sim:
	verilator --binary --timing --assert -Wno-fatal -f execute_unit.f \
		--top-module execute_unit_tb -Mdir obj_dir
	-./obj_dir/Vexecute_unit_tb > $(LOG) 2>&1
	cat $(LOG)
	grep -q "^TESTBENCH PASSED$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* execute_unit.f */
+incdir+rtl
rtl/pdp11_isa_pkg.sv
rtl/exe_pkg.sv
rtl/word_alu.sv
rtl/branch_unit.sv
rtl/ash_shifter.sv
rtl/shift_counter.sv
rtl/e1_sequencer.sv
rtl/execute_unit.sv
tb/execute_unit_sva.sv
tb/execute_unit_tb.sv

/* rtl/ash_shifter.sv */
/*
 * ash datapath: one bit position per step, left with zero fill
 * or arithmetic right, tracking the last bit out and sign changes
 */
`timescale 1ns/1ns
`include "exe_cfg.svh"

module ash_shifter (
   input  logic                        clk,
   input  logic                        rst_n,
   input  logic                        load,
   input  logic                        step,
   input  logic [`EXE_WORD_W-1:0]      operand,
   input  logic [`EXE_SHIFT_CNT_W-1:0] shift_amt,
   output logic [`EXE_WORD_W-1:0]      sh_result,
   output logic                        last_bit,
   output logic                        sign_changed
);

   localparam int W  = `EXE_WORD_W;
   localparam int CW = `EXE_SHIFT_CNT_W;

   logic [W-1:0] sh_q;
   logic         dir_left;

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         sh_q         <= '0;
         dir_left     <= 1'b0;
         last_bit     <= 1'b0;
         sign_changed <= 1'b0;
      end
      else if (load)
      begin
         sh_q         <= operand;
         // negative count shifts right
         dir_left     <= ~shift_amt[CW-1];
         last_bit     <= 1'b0;
         sign_changed <= 1'b0;
      end
      else if (step)
      begin
         if (dir_left)
         begin
            sh_q     <= {sh_q[W-2:0], 1'b0};
            last_bit <= sh_q[W-1];
            // sticky once the sign has flipped
            if (sh_q[W-1] != sh_q[W-2])
               sign_changed <= 1'b1;
         end
         else
         begin
            sh_q     <= {sh_q[W-1], sh_q[W-1:1]};
            last_bit <= sh_q[0];
         end
      end
   end

   assign sh_result = sh_q;

endmodule

/* rtl/branch_unit.sv */
/*
 * branch unit: word-offset target and taken decision for the
 * fifteen conditional and unconditional branches
 */
`timescale 1ns/1ns
`include "exe_cfg.svh"

module branch_unit
   import pdp11_isa_pkg::*;
   import exe_pkg::*;
(
   input  logic                   enable,
   input  isn_t                   isn,
   input  logic [`EXE_WORD_W-1:0] pc,
   input  cc_t                    cc,
   output logic [`EXE_WORD_W-1:0] new_pc,
   output logic                   latch_pc
);

   localparam int W = `EXE_WORD_W;

   logic [W-1:0] target;
   logic         is_br;
   logic         cond;

   // offset is in words, so sign extend and double
   assign target = pc + {{(W-9){isn.br.offset[7]}}, isn.br.offset, 1'b0};

   always_comb
   begin
      is_br = 1'b1;
      cond  = 1'b0;
      case (isn.br.code)
         BR_BR:   cond = 1'b1;
         BR_BNE:  cond = ~cc.z;
         BR_BEQ:  cond = cc.z;
         BR_BGE:  cond = ~(cc.n ^ cc.v);
         BR_BLT:  cond = cc.n ^ cc.v;
         BR_BGT:  cond = ~(cc.z | (cc.n ^ cc.v));
         BR_BLE:  cond = cc.z | (cc.n ^ cc.v);
         BR_BPL:  cond = ~cc.n;
         BR_BMI:  cond = cc.n;
         BR_BHI:  cond = ~(cc.c | cc.z);
         BR_BLOS: cond = cc.c | cc.z;
         BR_BVC:  cond = ~cc.v;
         BR_BVS:  cond = cc.v;
         BR_BCC:  cond = ~cc.c;
         BR_BCS:  cond = cc.c;
         default: is_br = 1'b0;
      endcase
   end

   assign new_pc   = (enable && is_br) ? target : '0;
   assign latch_pc = enable & is_br & cond;

endmodule

/* rtl/e1_sequencer.sv */
/*
 * e1 sequencer: idle/shift/done control for ash and the e1_advance strobe
 */
`timescale 1ns/1ns

module e1_sequencer
   import exe_pkg::*;
(
   input  logic clk,
   input  logic rst_n,
   input  logic enable,
   input  logic ash_req,
   input  logic count_zero,
   output logic load,
   output logic step,
   output logic ash_done,
   output logic e1_advance
);

   seq_state_e state;
   seq_state_e state_nxt;

   always_comb
   begin
      state_nxt = state;
      case (state)
         SEQ_IDLE:
            if (ash_req)
               state_nxt = count_zero ? SEQ_DONE : SEQ_SHIFT;
         SEQ_SHIFT:
            if (count_zero)
               state_nxt = SEQ_DONE;
         default:
            state_nxt = SEQ_IDLE;
      endcase
   end

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         state <= SEQ_IDLE;
      else
         state <= state_nxt;
   end

   assign load     = (state == SEQ_IDLE) && ash_req;
   assign step     = (state == SEQ_SHIFT);
   assign ash_done = (state == SEQ_DONE);

   // single cycle ops advance at once
   assign e1_advance = enable && (((state == SEQ_IDLE) && !ash_req) || ash_done);

endmodule

/* rtl/exe_cfg.svh */
/*
 * execute stage sizes: data word width and signed ash count width
 */
`ifndef EXE_CFG_SVH
`define EXE_CFG_SVH

// data word
`define EXE_WORD_W 16

// signed shift count taken from the low bits of the count operand
`define EXE_SHIFT_CNT_W 6

`endif

/* rtl/exe_pkg.sv */
/*
 * execute stage types: condition code bundle and ash sequencer states
 */
package exe_pkg;

   // same bit order as the low nibble of the psw
   typedef struct packed {
      logic n;
      logic z;
      logic v;
      logic c;
   } cc_t;

   // multi-cycle ash control
   typedef enum logic [1:0] {
      SEQ_IDLE  = 2'd0,
      SEQ_SHIFT = 2'd1,
      SEQ_DONE  = 2'd2
   } seq_state_e;

endpackage

/* rtl/execute_unit.sv */
/*
 * e1 execute stage top: word alu, branch unit and the ash
 * shifter, counter and sequencer
 */
`timescale 1ns/1ns
`include "exe_cfg.svh"

module execute_unit
   import pdp11_isa_pkg::*;
   import exe_pkg::*;
(
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic                   enable,
   input  isn_t                   isn,
   input  logic [`EXE_WORD_W-1:0] pc,
   input  logic [`EXE_WORD_W-1:0] ss_data,
   input  logic [`EXE_WORD_W-1:0] dd_data,
   input  cc_t                    cc,
   output logic [`EXE_WORD_W-1:0] e1_result,
   output cc_t                    new_cc,
   output logic                   latch_cc,
   output logic [`EXE_WORD_W-1:0] new_pc,
   output logic                   latch_pc,
   output logic                   e1_advance
);

   logic                   ash_req;
   logic                   load;
   logic                   step;
   logic                   ash_done;
   logic                   count_zero;
   logic [`EXE_WORD_W-1:0] sh_result;
   logic                   last_bit;
   logic                   sign_changed;

   word_alu alu0 (
      .enable(enable), .isn(isn), .ss_data(ss_data), .dd_data(dd_data), .cc(cc),
      .ash_done(ash_done), .sh_result(sh_result), .last_bit(last_bit),
      .sign_changed(sign_changed), .e1_result(e1_result), .new_cc(new_cc),
      .latch_cc(latch_cc), .ash_req(ash_req)
   );

   branch_unit br0 (
      .enable(enable), .isn(isn), .pc(pc), .cc(cc),
      .new_pc(new_pc), .latch_pc(latch_pc)
   );

   // ash shifts the source word by the signed count in dd
   ash_shifter sh0 (
      .clk(clk), .rst_n(rst_n), .load(load), .step(step), .operand(ss_data),
      .shift_amt(dd_data[`EXE_SHIFT_CNT_W-1:0]), .sh_result(sh_result),
      .last_bit(last_bit), .sign_changed(sign_changed)
   );

   shift_counter cnt0 (
      .clk(clk), .rst_n(rst_n), .load(load), .step(step),
      .shift_amt(dd_data[`EXE_SHIFT_CNT_W-1:0]), .count_zero(count_zero)
   );

   e1_sequencer seq0 (
      .clk(clk), .rst_n(rst_n), .enable(enable), .ash_req(ash_req),
      .count_zero(count_zero), .load(load), .step(step), .ash_done(ash_done),
      .e1_advance(e1_advance)
   );

endmodule

/* rtl/pdp11_isa_pkg.sv */
/*
 * pdp-11 instruction word encodings: major opcodes, branch codes
 * and the instruction word union with its operate and branch views
 */
package pdp11_isa_pkg;

   // isn[15:12]
   typedef enum logic [3:0] {
      OP_GRP0  = 4'o00,
      OP_MOV   = 4'o01,
      OP_CMP   = 4'o02,
      OP_BIT   = 4'o03,
      OP_BIC   = 4'o04,
      OP_BIS   = 4'o05,
      OP_ADD   = 4'o06,
      OP_GRP7  = 4'o07,
      OP_GRP10 = 4'o10,
      OP_SUB   = 4'o16
   } major_op_e;

   // isn[15:8] of the word branches
   typedef enum logic [7:0] {
      BR_BR   = 8'h01,
      BR_BNE  = 8'h02,
      BR_BEQ  = 8'h03,
      BR_BGE  = 8'h04,
      BR_BLT  = 8'h05,
      BR_BGT  = 8'h06,
      BR_BLE  = 8'h07,
      BR_BPL  = 8'h80,
      BR_BMI  = 8'h81,
      BR_BHI  = 8'h82,
      BR_BLOS = 8'h83,
      BR_BVC  = 8'h84,
      BR_BVS  = 8'h85,
      BR_BCC  = 8'h86,
      BR_BCS  = 8'h87
   } branch_code_e;

   typedef struct packed {
      major_op_e  major;
      logic [5:0] minor;
      logic [5:0] dst;
   } op_view_t;

   // offset counts words
   typedef struct packed {
      branch_code_e      code;
      logic signed [7:0] offset;
   } br_view_t;

   typedef union packed {
      op_view_t op;
      br_view_t br;
   } isn_t;

endpackage

/* rtl/shift_counter.sv */
/*
 * ash position counter, loaded with the count magnitude
 */
`timescale 1ns/1ns
`include "exe_cfg.svh"

module shift_counter (
   input  logic                        clk,
   input  logic                        rst_n,
   input  logic                        load,
   input  logic                        step,
   input  logic [`EXE_SHIFT_CNT_W-1:0] shift_amt,
   output logic                        count_zero
);

   localparam int CW = `EXE_SHIFT_CNT_W;

   logic [CW-1:0] cnt;
   logic [CW-1:0] cnt_nxt;
   logic [CW-1:0] mag;

   // -32 gives 6'b100000, which reads back as 32
   assign mag = shift_amt[CW-1] ? -shift_amt : shift_amt;

   always_comb
   begin
      cnt_nxt = cnt;
      if (load)
         cnt_nxt = mag;
      else if (step && cnt != '0)
         cnt_nxt = cnt - 1'b1;
   end

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         cnt <= '0;
      else
         cnt <= cnt_nxt;
   end

   // looks at the value after this edge so the sequencer leaves shift on time
   assign count_zero = (cnt_nxt == '0);

endmodule

/* rtl/word_alu.sv */
/*
 * word alu: double and single operand word ops, cc clear/set,
 * ash result selection and the ash request
 */
`timescale 1ns/1ns
`include "exe_cfg.svh"

module word_alu
   import pdp11_isa_pkg::*;
   import exe_pkg::*;
(
   input  logic                   enable,
   input  isn_t                   isn,
   input  logic [`EXE_WORD_W-1:0] ss_data,
   input  logic [`EXE_WORD_W-1:0] dd_data,
   input  cc_t                    cc,
   input  logic                   ash_done,
   input  logic [`EXE_WORD_W-1:0] sh_result,
   input  logic                   last_bit,
   input  logic                   sign_changed,
   output logic [`EXE_WORD_W-1:0] e1_result,
   output cc_t                    new_cc,
   output logic                   latch_cc,
   output logic                   ash_req
);

   localparam int W = `EXE_WORD_W;
   localparam logic [W-1:0] MOST_NEG = {1'b1, {(W-1){1'b0}}};
   localparam logic [W-1:0] MOST_POS = ~MOST_NEG;

   logic [W:0]   wide;
   logic [W-1:0] res;
   cc_t          cc_next;
   logic         upd_nz;
   logic         latch;
   logic         is_ash;

   assign is_ash  = (isn.op.major == OP_GRP7) && (isn.op.minor[5:3] == 3'd2);
   assign ash_req = enable & is_ash;

   always_comb
   begin
      wide    = '0;
      res     = '0;
      cc_next = cc;
      upd_nz  = 1'b0;
      latch   = 1'b0;
      if (enable)
      begin
         case (isn.op.major)
            OP_MOV:
            begin
               res = ss_data;
               cc_next.v = 1'b0;
               upd_nz = 1'b1;
            end
            OP_CMP:
            begin
               // ss - dd, carry bit is the borrow
               wide = {1'b0, ss_data} - {1'b0, dd_data};
               res = wide[W-1:0];
               cc_next.v = (ss_data[W-1] ^ dd_data[W-1]) & (res[W-1] ^ ss_data[W-1]);
               cc_next.c = wide[W];
               upd_nz = 1'b1;
            end
            OP_BIT:
            begin
               res = ss_data & dd_data;
               cc_next.v = 1'b0;
               upd_nz = 1'b1;
            end
            OP_BIC:
            begin
               res = ~ss_data & dd_data;
               cc_next.v = 1'b0;
               upd_nz = 1'b1;
            end
            OP_BIS:
            begin
               res = ss_data | dd_data;
               cc_next.v = 1'b0;
               upd_nz = 1'b1;
            end
            OP_ADD:
            begin
               wide = {1'b0, ss_data} + {1'b0, dd_data};
               res = wide[W-1:0];
               cc_next.v = (ss_data[W-1] ~^ dd_data[W-1]) & (res[W-1] ^ ss_data[W-1]);
               cc_next.c = wide[W];
               upd_nz = 1'b1;
            end
            OP_SUB:
            begin
               // dd - ss
               wide = {1'b0, dd_data} - {1'b0, ss_data};
               res = wide[W-1:0];
               cc_next.v = (ss_data[W-1] ^ dd_data[W-1]) & (res[W-1] ^ dd_data[W-1]);
               cc_next.c = wide[W];
               upd_nz = 1'b1;
            end
            OP_GRP7:
            begin
               if (is_ash)
               begin
                  // flags only valid once the shifter has finished
                  res = sh_result;
                  cc_next.v = sign_changed;
                  cc_next.c = last_bit;
                  upd_nz = 1'b1;
               end
               else if (isn.op.minor[5:3] == 3'd4)
               begin
                  res = ss_data ^ dd_data;
                  cc_next.v = 1'b0;
                  upd_nz = 1'b1;
               end
            end
            OP_GRP0:
            begin
               if (isn.op.minor == 6'o02 && isn.op.dst[5])
               begin
                  // 000240-000277, bit 4 picks set over clear
                  if (isn.op.dst[4])
                     cc_next = cc_t'(cc | isn.op.dst[3:0]);
                  else
                     cc_next = cc_t'(cc & ~isn.op.dst[3:0]);
                  latch = 1'b1;
               end
               else
               begin
                  upd_nz = 1'b1;
                  case (isn.op.minor)
                     6'o50:
                     begin
                        res = '0;
                        cc_next.v = 1'b0;
                        cc_next.c = 1'b0;
                     end
                     6'o51:
                     begin
                        res = ~dd_data;
                        cc_next.v = 1'b0;
                        cc_next.c = 1'b1;
                     end
                     6'o52:
                     begin
                        res = dd_data + 1'b1;
                        cc_next.v = (res == MOST_NEG);
                     end
                     6'o53:
                     begin
                        res = dd_data - 1'b1;
                        cc_next.v = (res == MOST_POS);
                     end
                     6'o54:
                     begin
                        res = -dd_data;
                        cc_next.v = (res == MOST_NEG);
                        cc_next.c = |dd_data;
                     end
                     6'o57:
                     begin
                        res = dd_data;
                        cc_next.v = 1'b0;
                        cc_next.c = 1'b0;
                     end
                     6'o60:
                     begin
                        // ror through carry
                        res = {cc.c, dd_data[W-1:1]};
                        cc_next.c = dd_data[0];
                        cc_next.v = res[W-1] ^ dd_data[0];
                     end
                     6'o61:
                     begin
                        res = {dd_data[W-2:0], cc.c};
                        cc_next.c = dd_data[W-1];
                        cc_next.v = res[W-1] ^ dd_data[W-1];
                     end
                     6'o62:
                     begin
                        res = {dd_data[W-1], dd_data[W-1:1]};
                        cc_next.c = dd_data[0];
                        cc_next.v = res[W-1] ^ dd_data[0];
                     end
                     6'o63:
                     begin
                        res = {dd_data[W-2:0], 1'b0};
                        cc_next.c = dd_data[W-1];
                        cc_next.v = res[W-1] ^ dd_data[W-1];
                     end
                     default:
                        upd_nz = 1'b0;
                  endcase
               end
            end
            default:
               upd_nz = 1'b0;
         endcase

         if (upd_nz)
         begin
            cc_next.n = res[W-1];
            cc_next.z = (res == '0);
            latch = is_ash ? ash_done : 1'b1;
         end
      end
   end

   assign e1_result = res;
   assign new_cc    = cc_next;
   assign latch_cc  = latch;

endmodule

/* tb/execute_unit_sva.sv */
/*
 * bound checks on the execute stage strobes and ash sequencing
 */
`timescale 1ns/1ns

module execute_unit_sva (
   input logic clk,
   input logic rst_n,
   input logic enable,
   input logic ash_req,
   input logic load,
   input logic step,
   input logic ash_done,
   input logic latch_cc,
   input logic latch_pc,
   input logic e1_advance
);

   // no strobes without enable
   quiet_when_idle: assert property (@(posedge clk) disable iff (!rst_n)
      !enable |-> !latch_cc && !latch_pc && !e1_advance)
   else
      $error("strobe raised while enable is low");

   // done cycle advances the stage
   done_advances: assert property (@(posedge clk) disable iff (!rst_n)
      ash_done |-> e1_advance)
   else
      $error("ash finished without e1_advance");

   // a held ash restarts from idle without a second advance
   done_single: assert property (@(posedge clk) disable iff (!rst_n)
      ash_done ##1 ash_req |-> !e1_advance)
   else
      $error("e1_advance held for more than one cycle after ash");

   // load leaves idle on the next edge
   load_in_idle: assert property (@(posedge clk) disable iff (!rst_n)
      load |=> step || ash_done)
   else
      $error("sequencer stayed in idle after load");

   done_latches: assert property (@(posedge clk) disable iff (!rst_n)
      ash_done |-> latch_cc)
   else
      $error("ash done without latch_cc");

   shift_quiet: assert property (@(posedge clk) disable iff (!rst_n)
      step |-> !e1_advance && !latch_cc && !latch_pc)
   else
      $error("strobe raised while ash is shifting");

endmodule

bind execute_unit execute_unit_sva sva0 (
   .clk(clk), .rst_n(rst_n), .enable(enable), .ash_req(ash_req), .load(load),
   .step(step), .ash_done(ash_done), .latch_cc(latch_cc), .latch_pc(latch_pc),
   .e1_advance(e1_advance)
);

/* tb/execute_unit_tb.sv */
/*
 * execute stage testbench: clock, reset, random and edge stimulus,
 * reference model for results, flags, branches and ash timing
 */
`timescale 1ns/1ns
`include "exe_cfg.svh"

module execute_unit_tb
   import pdp11_isa_pkg::*;
   import exe_pkg::*;
();

   localparam int W = `EXE_WORD_W;

   logic         clk;
   logic         rst_n;
   logic         enable;
   isn_t         isn;
   logic [W-1:0] pc;
   logic [W-1:0] ss_data;
   logic [W-1:0] dd_data;
   cc_t          cc;
   logic [W-1:0] e1_result;
   cc_t          new_cc;
   logic         latch_cc;
   logic [W-1:0] new_pc;
   logic         latch_pc;
   logic         e1_advance;

   int checks;
   int errors;
   int err0;
   int sel;
   int edges;
   int shift_mag;

   isn_t              op_isn;
   logic [W-1:0]      op_ss;
   logic [W-1:0]      op_dd;
   logic [W-1:0]      op_pc;
   cc_t               op_cc;
   logic signed [7:0] op_off;
   logic [3:0]        op_mask;
   logic              op_set;
   logic [W-1:0]      exp_res;
   logic [W-1:0]      exp_pc;
   cc_t               exp_cc;

   major_op_e    dbl_ops[7] = '{OP_MOV, OP_CMP, OP_BIT, OP_BIC, OP_BIS, OP_ADD, OP_SUB};
   logic [5:0]   single_ops[10] = '{6'o50, 6'o51, 6'o52, 6'o53, 6'o54,
                                    6'o57, 6'o60, 6'o61, 6'o62, 6'o63};
   logic [W-1:0] edge_vals[4] = '{16'o000000, 16'o077777, 16'o100000, 16'o177777};
   branch_code_e br_codes[15] = '{BR_BR, BR_BNE, BR_BEQ, BR_BGE, BR_BLT, BR_BGT, BR_BLE,
                                  BR_BPL, BR_BMI, BR_BHI, BR_BLOS, BR_BVC, BR_BVS,
                                  BR_BCC, BR_BCS};
   int           ash_counts[8] = '{0, 1, 15, 16, 31, -1, -16, -32};

   execute_unit dut0 (
      .clk(clk), .rst_n(rst_n), .enable(enable), .isn(isn), .pc(pc),
      .ss_data(ss_data), .dd_data(dd_data), .cc(cc), .e1_result(e1_result),
      .new_cc(new_cc), .latch_cc(latch_cc), .new_pc(new_pc), .latch_pc(latch_pc),
      .e1_advance(e1_advance)
   );

   always #10 clk = ~clk;

   task automatic check_word(input string name, input logic [W-1:0] got,
                             input logic [W-1:0] exp);
      checks++;
      assert (got === exp)
      else
      begin
         errors++;
         $display("FAIL %s got 0x%h expected 0x%h", name, got, exp);
      end
   endtask

   task automatic check_cc(input string name, input cc_t got, input cc_t exp);
      checks++;
      assert (got === exp)
      else
      begin
         errors++;
         $display("FAIL %s got 0x%h expected 0x%h", name, got, exp);
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      checks++;
      assert (got === exp)
      else
      begin
         errors++;
         $display("FAIL %s got 0x%h expected 0x%h", name, got, exp);
      end
   endtask

   task automatic check_outputs(input logic [W-1:0] r, input cc_t c, input logic lc);
      check_word("e1_result", e1_result, r);
      check_cc("new_cc", new_cc, c);
      check_bit("latch_cc", latch_cc, lc);
      check_bit("latch_pc", latch_pc, 1'b0);
   endtask

   task automatic drive_inputs(input logic en, input isn_t ins, input logic [W-1:0] p,
                               input logic [W-1:0] s, input logic [W-1:0] d,
                               input cc_t c);
      @(posedge clk);
      #2;
      enable  = en;
      isn     = ins;
      pc      = p;
      ss_data = s;
      dd_data = d;
      cc      = c;
   endtask

   // counts rising edges until e1_advance, strobes must stay low meanwhile
   task automatic wait_advance(output int n_edges);
      n_edges = 0;
      @(negedge clk);
      while (!e1_advance && n_edges < 40)
      begin
         check_bit("latch_cc", latch_cc, 1'b0);
         check_bit("latch_pc", latch_pc, 1'b0);
         @(posedge clk);
         n_edges++;
         @(negedge clk);
      end
      if (!e1_advance)
      begin
         errors++;
         $display("timeout, e1_advance did not rise within 40 cycles");
      end
   endtask

   task automatic model_double(input isn_t ins, input logic [W-1:0] s,
                               input logic [W-1:0] d, input cc_t c,
                               output logic [W-1:0] r, output cc_t nc);
      logic [W:0] sum;
      nc = c;
      nc.v = 1'b0;
      sum = {1'b0, s} + {1'b0, d};
      case (ins.op.major)
         OP_MOV: r = s;
         OP_BIT: r = s & d;
         OP_BIC: r = ~s & d;
         OP_BIS: r = s | d;
         OP_CMP:
         begin
            r = s - d;
            nc.v = (s[W-1] != d[W-1]) && (r[W-1] != s[W-1]);
            nc.c = (s < d);
         end
         OP_ADD:
         begin
            r = sum[W-1:0];
            nc.v = (s[W-1] == d[W-1]) && (r[W-1] != s[W-1]);
            nc.c = sum[W];
         end
         OP_SUB:
         begin
            r = d - s;
            nc.v = (s[W-1] != d[W-1]) && (r[W-1] != d[W-1]);
            nc.c = (d < s);
         end
         // xor sits in group 7
         default: r = s ^ d;
      endcase
      nc.n = r[W-1];
      nc.z = (r == '0);
   endtask

   task automatic model_single(input logic [5:0] minor, input logic [W-1:0] d,
                               input cc_t c, output logic [W-1:0] r, output cc_t nc);
      nc = c;
      case (minor)
         6'o50: r = '0;
         6'o51: r = ~d;
         6'o52: r = d + 16'd1;
         6'o53: r = d - 16'd1;
         6'o54: r = 16'd0 - d;
         6'o57: r = d;
         6'o60: r = {c.c, d[W-1:1]};
         6'o61: r = {d[W-2:0], c.c};
         6'o62: r = {d[W-1], d[W-1:1]};
         default: r = {d[W-2:0], 1'b0};
      endcase
      nc.n = r[W-1];
      nc.z = (r == '0);
      case (minor)
         6'o50, 6'o57: nc[1:0] = 2'b00;
         6'o51: nc[1:0] = 2'b01;
         6'o52: nc.v = (r == 16'o100000);
         6'o53: nc.v = (r == 16'o077777);
         6'o54:
         begin
            nc.v = (r == 16'o100000);
            nc.c = ~nc.z;
         end
         default:
         begin
            // shifts and rotates: c is the bit shifted out
            nc.c = (minor == 6'o60 || minor == 6'o62) ? d[0] : d[W-1];
            nc.v = nc.n ^ nc.c;
         end
      endcase
   endtask

   function automatic logic branch_taken(input branch_code_e code, input cc_t f);
      case (code)
         BR_BR:   return 1'b1;
         BR_BNE:  return !f.z;
         BR_BEQ:  return f.z;
         BR_BGE:  return f.n == f.v;
         BR_BLT:  return f.n != f.v;
         BR_BGT:  return !f.z && (f.n == f.v);
         BR_BLE:  return f.z || (f.n != f.v);
         BR_BPL:  return !f.n;
         BR_BMI:  return f.n;
         BR_BHI:  return !f.c && !f.z;
         BR_BLOS: return f.c || f.z;
         BR_BVC:  return !f.v;
         BR_BVS:  return f.v;
         BR_BCC:  return !f.c;
         default: return f.c;
      endcase
   endfunction

   // positive count shifts left with zero fill, negative shifts right
   task automatic model_ash(input logic [W-1:0] s, input int count,
                            output logic [W-1:0] r, output cc_t nc);
      int   mag;
      logic lb;
      logic sc;
      mag = (count < 0) ? -count : count;
      r = s;
      lb = 1'b0;
      sc = 1'b0;
      for (int k = 0; k < mag; k++)
      begin
         if (count > 0)
         begin
            lb = r[W-1];
            r = r << 1;
            if (r[W-1] != lb)
               sc = 1'b1;
         end
         else
         begin
            lb = r[0];
            r = {r[W-1], r[W-1:1]};
         end
      end
      nc.n = r[W-1];
      nc.z = (r == '0);
      nc.v = sc;
      nc.c = lb;
   endtask

   task automatic end_test(input string name, input int err_start);
      $display("test %s finished with %0d errors", name, errors - err_start);
   endtask

   initial
   begin
      clk = 1'b0;
      rst_n = 1'b0;
      enable = 1'b0;
      isn = '0;
      pc = '0;
      ss_data = '0;
      dd_data = '0;
      cc = '0;
      checks = 0;
      errors = 0;
      void'($urandom(32'hadbe));
      repeat (5) @(posedge clk);
      #2;
      rst_n = 1'b1;

      err0 = errors;
      for (int t = 0; t < 48; t++)
      begin
         sel = $urandom_range(0, 7);
         if (sel == 7)
            op_isn = {OP_GRP7, 3'd4, 9'($urandom)};
         else
            op_isn = {dbl_ops[sel], 12'($urandom)};
         op_ss = W'($urandom);
         op_dd = W'($urandom);
         op_cc = cc_t'(4'($urandom));
         model_double(op_isn, op_ss, op_dd, op_cc, exp_res, exp_cc);
         drive_inputs(1'b1, op_isn, W'($urandom), op_ss, op_dd, op_cc);
         wait_advance(edges);
         check_word("e1_advance edges", W'(edges), '0);
         check_outputs(exp_res, exp_cc, 1'b1);
      end
      end_test("double operand", err0);

      err0 = errors;
      foreach (single_ops[m])
      begin
         for (int t = 0; t < 8; t++)
         begin
            op_dd = (t < 4) ? edge_vals[t] : W'($urandom);
            op_cc = cc_t'(4'($urandom));
            op_isn = {OP_GRP0, single_ops[m], 6'($urandom)};
            model_single(single_ops[m], op_dd, op_cc, exp_res, exp_cc);
            drive_inputs(1'b1, op_isn, W'($urandom), W'($urandom), op_dd, op_cc);
            wait_advance(edges);
            check_word("e1_advance edges", W'(edges), '0);
            check_outputs(exp_res, exp_cc, 1'b1);
         end
      end
      end_test("single operand", err0);

      err0 = errors;
      for (int b = 0; b < 15; b++)
      begin
         for (int f = 0; f < 16; f++)
         begin
            op_off = 8'($urandom);
            op_pc = W'($urandom);
            op_cc = cc_t'(4'(f));
            op_isn = {br_codes[b], op_off};
            exp_pc = op_pc + W'(int'(op_off) * 2);
            drive_inputs(1'b1, op_isn, op_pc, W'($urandom), W'($urandom), op_cc);
            wait_advance(edges);
            check_word("e1_advance edges", W'(edges), '0);
            check_word("new_pc", new_pc, exp_pc);
            check_bit("latch_pc", latch_pc, branch_taken(br_codes[b], op_cc));
            check_bit("latch_cc", latch_cc, 1'b0);
         end
      end
      end_test("branches", err0);

      err0 = errors;
      for (int t = 0; t < 24; t++)
      begin
         op_mask = 4'($urandom);
         op_set = 1'($urandom);
         op_cc = cc_t'(4'($urandom));
         op_isn = {OP_GRP0, 6'o02, 1'b1, op_set, op_mask};
         exp_cc = op_set ? cc_t'(op_cc | op_mask) : cc_t'(op_cc & ~op_mask);
         drive_inputs(1'b1, op_isn, W'($urandom), W'($urandom), W'($urandom), op_cc);
         wait_advance(edges);
         check_word("e1_advance edges", W'(edges), '0);
         check_cc("new_cc", new_cc, exp_cc);
         check_bit("latch_cc", latch_cc, 1'b1);
         check_bit("latch_pc", latch_pc, 1'b0);
      end
      end_test("condition code ops", err0);

      err0 = errors;
      foreach (ash_counts[j])
      begin
         for (int t = 0; t < 3; t++)
         begin
            shift_mag = (ash_counts[j] < 0) ? -ash_counts[j] : ash_counts[j];
            op_ss = W'($urandom);
            op_dd = {10'($urandom), 6'(ash_counts[j])};
            op_isn = {OP_GRP7, 3'd2, 9'($urandom)};
            model_ash(op_ss, ash_counts[j], exp_res, exp_cc);
            drive_inputs(1'b1, op_isn, W'($urandom), op_ss, op_dd, cc_t'(4'($urandom)));
            wait_advance(edges);
            check_word("e1_advance edges", W'(edges), W'(shift_mag + 1));
            check_outputs(exp_res, exp_cc, 1'b1);
         end
      end
      end_test("ash", err0);

      err0 = errors;
      for (int t = 0; t < 20; t++)
      begin
         drive_inputs(1'b0, W'($urandom), W'($urandom), W'($urandom), W'($urandom),
                      cc_t'(4'($urandom)));
         @(negedge clk);
         check_bit("latch_cc", latch_cc, 1'b0);
         check_bit("latch_pc", latch_pc, 1'b0);
         check_bit("e1_advance", e1_advance, 1'b0);
      end
      end_test("enable low", err0);

      $display("%0d checks, %0d errors", checks, errors);
      if (errors == 0)
         $display("TESTBENCH PASSED");
      else
         $display("TESTBENCH FAILED");
      $finish;
   end

endmodule
